/* hw/bridge_settings.svh */
/*
 * Build settings for the RVFI to RVVI trace bridge.
 * Holds widths, buffer depth and the cause codes the decoder looks for.
 * Include it in any file that sizes a signal or compares a cause.
 */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Datapath and register file
`define BRIDGE_XLEN          32
`define BRIDGE_NUM_GPR       32
`define BRIDGE_GPR_IDX_W     5
`define BRIDGE_ORDER_W       64
`define BRIDGE_CAUSE_W       11

// Record buffer between decoder and sequencer
`define BRIDGE_FIFO_DEPTH    8

// Cause codes
`define BRIDGE_CAUSE_IBUS_FAULT  48
`define BRIDGE_NMI_LOAD_CAUSE    1024
`define BRIDGE_NMI_STORE_CAUSE   1025

// dbg field value for an external halt request
`define BRIDGE_DBG_HALTREQ   3

`endif

/* hw/net_pkg.sv */
/*
 * Net change message types.
 * The sequencer sends one net_msg_t per changed asynchronous net,
 * the id also gives the order in which nets are reported.
 */
`include "bridge_settings.svh"

package net_pkg;

   // Encoding doubles as the send priority, lowest first
   typedef enum logic [1:0] {
      NET_NMI_CAUSE  = 2'd0,
      NET_NMI        = 2'd1,
      NET_IBUS_FAULT = 2'd2,
      NET_HALTREQ    = 2'd3
   } net_id_t;

   localparam int NUM_NETS = 4;

   // 1-bit nets travel in bit 0 of value
   typedef struct packed {
      net_id_t                    id;
      logic [`BRIDGE_CAUSE_W-1:0] value;
   } net_msg_t;

endpackage

/* hw/net_sequencer.sv */
/*
 * Output sequencer.
 * Pops one record at a time, presents it as a trace strobe and then
 * sends one message per net whose level differs from the last sent one.
 */
`include "bridge_settings.svh"

module net_sequencer
   import trace_pkg::*;
   import net_pkg::*;
(
   input  logic       rvvi,
   input  logic       rst_n,
   input  logic       empty,
   input  trace_rec_t head_rec,
   output logic       pop,
   output logic       trace_valid,
   output trace_rec_t trace,
   output logic       net_valid,
   output net_msg_t   net
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_TRACE,
      S_MSG
   } state_t;

   state_t                     state;
   trace_rec_t                 cur;
   logic [NUM_NETS-1:0]        pend;
   logic [NUM_NETS-1:0]        chg;
   logic [NUM_NETS-1:0]        next_pend;
   net_id_t                    sel_id;
   logic [`BRIDGE_CAUSE_W-1:0] sent_cause;
   logic                       sent_nmi;
   logic                       sent_ibus;
   logic                       sent_halt;

   assign pop         = (state == S_IDLE) && !empty;
   assign trace_valid = (state == S_TRACE);
   assign trace       = cur;
   assign net_valid   = (state == S_MSG);

   // Change flags, sampled once when the record is taken
   always_comb begin
      chg                 = '0;
      chg[NET_NMI_CAUSE]  = head_rec.nmi_cause != sent_cause;
      chg[NET_NMI]        = head_rec.nmi != sent_nmi;
      chg[NET_IBUS_FAULT] = head_rec.ibus_fault != sent_ibus;
      chg[NET_HALTREQ]    = head_rec.haltreq != sent_halt;
   end

   //////////////////////////////////////////////////
   // Message select, fixed priority
   //////////////////////////////////////////////////
   always_comb begin
      if (pend[NET_NMI_CAUSE]) begin
         sel_id = NET_NMI_CAUSE;
      end else if (pend[NET_NMI]) begin
         sel_id = NET_NMI;
      end else if (pend[NET_IBUS_FAULT]) begin
         sel_id = NET_IBUS_FAULT;
      end else begin
         sel_id = NET_HALTREQ;
      end
      next_pend = pend & ~(NUM_NETS'(1) << sel_id);
   end

   always_comb begin
      net.id    = sel_id;
      net.value = '0;
      case (sel_id)
         NET_NMI_CAUSE:  net.value    = cur.nmi_cause;
         NET_NMI:        net.value[0] = cur.nmi;
         NET_IBUS_FAULT: net.value[0] = cur.ibus_fault;
         default:        net.value[0] = cur.haltreq;
      endcase
   end

   //////////////////////////////////////////////////
   // FSM and sent levels
   //////////////////////////////////////////////////
   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         state      <= S_IDLE;
         pend       <= '0;
         sent_cause <= '0;
         sent_nmi   <= 1'b0;
         sent_ibus  <= 1'b0;
         sent_halt  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (pop) begin
                  state <= S_TRACE;
                  pend  <= chg;
               end
            end
            S_TRACE: begin
               state <= (pend != '0) ? S_MSG : S_IDLE;
            end
            S_MSG: begin
               pend <= next_pend;
               case (sel_id)
                  NET_NMI_CAUSE:  sent_cause <= cur.nmi_cause;
                  NET_NMI:        sent_nmi   <= cur.nmi;
                  NET_IBUS_FAULT: sent_ibus  <= cur.ibus_fault;
                  default:        sent_halt  <= cur.haltreq;
               endcase
               // Back to idle after the last changed net
               if (next_pend == '0) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Record in progress
   always_ff @(posedge rvvi) begin
      if (pop) begin
         cur <= head_rec;
      end
   end

endmodule

/* hw/record_fifo.sv */
/*
 * Circular buffer of decoded trace records.
 * A push into a full buffer is lost and sets a sticky overflow flag
 * that only reset clears.
 */
`include "bridge_settings.svh"

module record_fifo
   import trace_pkg::*;
(
   input  logic       rvvi,
   input  logic       rst_n,
   input  logic       push,
   input  trace_rec_t push_rec,
   input  logic       pop,
   output logic       empty,
   output logic       overflow,
   output trace_rec_t head_rec
);

   localparam int DEPTH = `BRIDGE_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   trace_rec_t       mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_push;
   logic             do_pop;

   // Wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);
   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;
   assign head_rec = mem[rd_ptr];

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (push && full) begin
            overflow <= 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge rvvi) begin
      if (do_push) begin
         mem[wr_ptr] <= push_rec;
      end
   end

endmodule

/* hw/retire_decoder.sv */
/*
 * Retirement decoder.
 * Accepts one RVFI record per strobe, drops repeated orders and
 * pushes a decoded trace record one cycle later.
 */
`include "bridge_settings.svh"

module retire_decoder
   import trace_pkg::*;
(
   input  logic       rvvi,
   input  logic       rst_n,
   input  logic       rvfi_valid,
   input  rvfi_rec_t  rvfi,
   output logic       push,
   output trace_rec_t push_rec
);

   localparam int NUM_GPR = `BRIDGE_NUM_GPR;
   localparam logic [5:0] IBUS_FAULT = 6'(`BRIDGE_CAUSE_IBUS_FAULT);
   localparam logic [`BRIDGE_CAUSE_W-1:0] NMI_LOAD  = `BRIDGE_CAUSE_W'(`BRIDGE_NMI_LOAD_CAUSE);
   localparam logic [`BRIDGE_CAUSE_W-1:0] NMI_STORE = `BRIDGE_CAUSE_W'(`BRIDGE_NMI_STORE_CAUSE);
   localparam logic [2:0] DBG_HALTREQ = 3'(`BRIDGE_DBG_HALTREQ);

   logic                       have_order;
   logic [`BRIDGE_ORDER_W-1:0] last_order;
   logic [`BRIDGE_CAUSE_W-1:0] nmi_cause_q;
   logic                       accept;
   logic                       nmi_hit;
   trace_rec_t                 rec_d;

   // First record after reset always passes
   assign accept = rvfi_valid && (!have_order || (rvfi.order != last_order));

   // Load or store error NMI, or NMI already pending
   assign nmi_hit = (rvfi.intr.intr && rvfi.intr.interrupt &&
                     ((rvfi.intr.cause == NMI_LOAD) || (rvfi.intr.cause == NMI_STORE)))
                    || rvfi.nmip[0];

   //////////////////////////////////////////////////
   // Record decode
   //////////////////////////////////////////////////
   always_comb begin
      rec_d           = '0;
      rec_d.order     = rvfi.order;
      rec_d.insn      = rvfi.insn;
      rec_d.mode      = rvfi.mode;
      rec_d.ixl       = rvfi.ixl;
      rec_d.pc_rdata  = rvfi.pc_rdata;
      rec_d.pc_wdata  = rvfi.pc_wdata;
      // Only the fetch fault is reported as a trap
      rec_d.trap_ibus = rvfi.trap.trap && rvfi.trap.exception &&
                        (rvfi.trap.exception_cause == IBUS_FAULT);

      // x0 is never written
      if (rvfi.rd_addr != '0) begin
         rec_d.x_wb = NUM_GPR'(1) << rvfi.rd_addr;
      end
      rec_d.x_wdata   = rvfi.rd_wdata;

      // Written bits from wdata, the rest from rdata
      rec_d.csr_addr  = rvfi.csr_addr;
      rec_d.csr_value = (rvfi.csr_wdata & rvfi.csr_wmask) |
                        (rvfi.csr_rdata & ~rvfi.csr_wmask);
      rec_d.csr_wb    = |rvfi.csr_wmask;

      // Net levels
      rec_d.nmi        = nmi_hit;
      rec_d.nmi_cause  = nmi_hit ? rvfi.intr.cause : nmi_cause_q;
      rec_d.ibus_fault = rec_d.trap_ibus;
      rec_d.haltreq    = (rvfi.dbg == DBG_HALTREQ) && rvfi.dbg_mode;
   end

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         push        <= 1'b0;
         have_order  <= 1'b0;
         last_order  <= '0;
         nmi_cause_q <= '0;
      end else begin
         push <= accept;
         if (accept) begin
            have_order  <= 1'b1;
            last_order  <= rvfi.order;
            nmi_cause_q <= rec_d.nmi_cause;
         end
      end
   end

   always_ff @(posedge rvvi) begin
      if (accept) begin
         push_rec <= rec_d;
      end
   end

endmodule

/* hw/rvfi_trace_bridge.sv */
/*
 * RVFI to RVVI trace bridge, top level.
 * Decoder, record buffer and sequencer in a row. Inputs are a plain
 * retirement strobe, outputs are trace and net message strobes.
 */
module rvfi_trace_bridge
   import trace_pkg::*;
   import net_pkg::*;
(
   input  logic       rvvi,
   input  logic       rst_n,
   input  logic       rvfi_valid,
   input  rvfi_rec_t  rvfi,
   output logic       trace_valid,
   output trace_rec_t trace,
   output logic       net_valid,
   output net_msg_t   net,
   output logic       overflow
);

   logic       push;
   trace_rec_t push_rec;
   logic       pop;
   logic       empty;
   trace_rec_t head_rec;

   retire_decoder i_retire_decoder (
      .rvvi       (rvvi),
      .rst_n      (rst_n),
      .rvfi_valid (rvfi_valid),
      .rvfi       (rvfi),
      .push       (push),
      .push_rec   (push_rec)
   );

   record_fifo i_record_fifo (
      .rvvi     (rvvi),
      .rst_n    (rst_n),
      .push     (push),
      .push_rec (push_rec),
      .pop      (pop),
      .empty    (empty),
      .overflow (overflow),
      .head_rec (head_rec)
   );

   net_sequencer i_net_sequencer (
      .rvvi        (rvvi),
      .rst_n       (rst_n),
      .empty       (empty),
      .head_rec    (head_rec),
      .pop         (pop),
      .trace_valid (trace_valid),
      .trace       (trace),
      .net_valid   (net_valid),
      .net         (net)
   );

endmodule

/* hw/trace_pkg.sv */
/*
 * Record types for the trace bridge.
 * rvfi_rec_t is one RVFI retirement as seen on the input port,
 * trace_rec_t is the decoded record that travels through the buffer.
 */
`include "bridge_settings.svh"

package trace_pkg;

   typedef struct packed {
      logic       trap;
      logic       exception;
      logic       debug;
      logic [5:0] exception_cause;
      logic [2:0] debug_cause;
      logic [1:0] cause_type;
   } rvfi_trap_t;

   typedef struct packed {
      logic                       intr;
      logic                       exception;
      logic                       interrupt;
      logic [`BRIDGE_CAUSE_W-1:0] cause;
   } rvfi_intr_t;

   // One retirement from the core
   typedef struct packed {
      logic [`BRIDGE_ORDER_W-1:0]   order;
      logic [`BRIDGE_XLEN-1:0]      insn;
      rvfi_trap_t                   trap;
      rvfi_intr_t                   intr;
      logic [2:0]                   dbg;
      logic                         dbg_mode;
      logic [1:0]                   nmip;
      logic [1:0]                   mode;
      logic [1:0]                   ixl;
      logic [`BRIDGE_XLEN-1:0]      pc_rdata;
      logic [`BRIDGE_XLEN-1:0]      pc_wdata;
      logic [`BRIDGE_GPR_IDX_W-1:0] rd_addr;
      logic [`BRIDGE_XLEN-1:0]      rd_wdata;
      logic [11:0]                  csr_addr;
      logic [`BRIDGE_XLEN-1:0]      csr_wdata;
      logic [`BRIDGE_XLEN-1:0]      csr_wmask;
      logic [`BRIDGE_XLEN-1:0]      csr_rdata;
   } rvfi_rec_t;

   // Decoded trace record, net levels included
   typedef struct packed {
      logic [`BRIDGE_ORDER_W-1:0] order;
      logic [`BRIDGE_XLEN-1:0]    insn;
      logic                       trap_ibus;
      logic [1:0]                 mode;
      logic [1:0]                 ixl;
      logic [`BRIDGE_XLEN-1:0]    pc_rdata;
      logic [`BRIDGE_XLEN-1:0]    pc_wdata;
      logic [`BRIDGE_NUM_GPR-1:0] x_wb;
      logic [`BRIDGE_XLEN-1:0]    x_wdata;
      logic [11:0]                csr_addr;
      logic [`BRIDGE_XLEN-1:0]    csr_value;
      logic                       csr_wb;
      logic                       nmi;
      logic [`BRIDGE_CAUSE_W-1:0] nmi_cause;
      logic                       ibus_fault;
      logic                       haltreq;
   } trace_rec_t;

endpackage

/* run_sim.sh */
#!/bin/bash
# Build the trace bridge testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_rvfi_trace_bridge -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Test passed$" sim.log 2>/dev/null \
   && echo "Simulation run passed" \
   || { echo "Simulation run failed"; exit 1; }

/* sources.f */
+incdir+hw
hw/trace_pkg.sv
hw/net_pkg.sv
hw/retire_decoder.sv
hw/record_fifo.sv
hw/net_sequencer.sv
hw/rvfi_trace_bridge.sv
test/bridge_assertions.sv
test/tb_clock_gen.sv
test/tb_rvfi_trace_bridge.sv

/* test/bridge_assertions.sv */
/*
 * Checker bound to the trace bridge top level.
 * Keeps an in-order model of accepted retirements and of the net levels
 * sent so far, and checks traces and net messages against it.
 */
`include "bridge_settings.svh"

module bridge_assertions
   import trace_pkg::*;
   import net_pkg::*;
(
   input logic       rvvi,
   input logic       rst_n,
   input logic       rvfi_valid,
   input rvfi_rec_t  rvfi,
   input logic       trace_valid,
   input trace_rec_t trace,
   input logic       net_valid,
   input net_msg_t   net,
   input logic       overflow
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MODEL_DEPTH = 64;

   trace_rec_t                 exp_mem [MODEL_DEPTH];
   logic [5:0]                 wr_idx;
   logic [5:0]                 rd_idx;
   int                         outstanding;
   logic                       have_order;
   logic [`BRIDGE_ORDER_W-1:0] last_order;
   logic [`BRIDGE_CAUSE_W-1:0] held_cause;
   logic                       seen_strobe;
   logic                       accept;
   trace_rec_t                 new_rec;
   trace_rec_t                 exp_head;
   trace_rec_t                 msg_rec;
   logic [NUM_NETS-1:0]        exp_pend;
   net_id_t                    exp_id;
   logic [`BRIDGE_CAUSE_W-1:0] exp_value;
   logic [`BRIDGE_CAUSE_W-1:0] prev_value;
   logic [`BRIDGE_CAUSE_W-1:0] sent_cause;
   logic                       sent_nmi;
   logic                       sent_ibus;
   logic                       sent_halt;

   // One flag per assertion, set by its action block
   logic f_quiet  = 1'b0;
   logic f_known  = 1'b0;
   logic f_match  = 1'b0;
   logic f_window = 1'b0;
   logic f_done   = 1'b0;
   logic f_order  = 1'b0;
   logic f_change = 1'b0;
   logic f_ovf    = 1'b0;
   logic failed;

   assign failed = f_quiet | f_known | f_match | f_window | f_done | f_order |
                   f_change | f_ovf;

   // Expected trace record, built bit by bit from the retirement
   function automatic trace_rec_t expect_rec(input rvfi_rec_t r,
                                             input logic [`BRIDGE_CAUSE_W-1:0] held);
      trace_rec_t e;
      logic       is_nmi;
      e          = '0;
      e.order    = r.order;
      e.insn     = r.insn;
      e.mode     = r.mode;
      e.ixl      = r.ixl;
      e.pc_rdata = r.pc_rdata;
      e.pc_wdata = r.pc_wdata;
      e.x_wdata  = r.rd_wdata;
      e.csr_addr = r.csr_addr;
      for (int i = 1; i < `BRIDGE_NUM_GPR; i++) begin
         e.x_wb[i] = (int'(r.rd_addr) == i);
      end
      for (int i = 0; i < `BRIDGE_XLEN; i++) begin
         e.csr_value[i] = r.csr_wmask[i] ? r.csr_wdata[i] : r.csr_rdata[i];
      end
      e.csr_wb    = (r.csr_wmask != '0);
      e.trap_ibus = r.trap.trap && r.trap.exception &&
                    (int'(r.trap.exception_cause) == `BRIDGE_CAUSE_IBUS_FAULT);
      is_nmi = r.nmip[0] ||
               (r.intr.intr && r.intr.interrupt &&
                (int'(r.intr.cause) == `BRIDGE_NMI_LOAD_CAUSE ||
                 int'(r.intr.cause) == `BRIDGE_NMI_STORE_CAUSE));
      e.nmi        = is_nmi;
      e.nmi_cause  = is_nmi ? r.intr.cause : held;
      e.ibus_fault = e.trap_ibus;
      e.haltreq    = r.dbg_mode && (int'(r.dbg) == `BRIDGE_DBG_HALTREQ);
      return e;
   endfunction

   assign accept   = rvfi_valid && (!have_order || (rvfi.order != last_order));
   assign new_rec  = expect_rec(rvfi, held_cause);
   assign exp_head = exp_mem[rd_idx];

   // Next net to report and the value it should carry
   always_comb begin
      if (exp_pend[NET_NMI_CAUSE]) begin
         exp_id = NET_NMI_CAUSE;
      end else if (exp_pend[NET_NMI]) begin
         exp_id = NET_NMI;
      end else if (exp_pend[NET_IBUS_FAULT]) begin
         exp_id = NET_IBUS_FAULT;
      end else begin
         exp_id = NET_HALTREQ;
      end
      exp_value  = '0;
      prev_value = '0;
      case (exp_id)
         NET_NMI_CAUSE:  exp_value    = msg_rec.nmi_cause;
         NET_NMI:        exp_value[0] = msg_rec.nmi;
         NET_IBUS_FAULT: exp_value[0] = msg_rec.ibus_fault;
         default:        exp_value[0] = msg_rec.haltreq;
      endcase
      case (net.id)
         NET_NMI_CAUSE:  prev_value    = sent_cause;
         NET_NMI:        prev_value[0] = sent_nmi;
         NET_IBUS_FAULT: prev_value[0] = sent_ibus;
         default:        prev_value[0] = sent_halt;
      endcase
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         wr_idx      <= '0;
         rd_idx      <= '0;
         outstanding <= 0;
         have_order  <= 1'b0;
         last_order  <= '0;
         held_cause  <= '0;
         seen_strobe <= 1'b0;
         exp_pend    <= '0;
         msg_rec     <= '0;
         sent_cause  <= '0;
         sent_nmi    <= 1'b0;
         sent_ibus   <= 1'b0;
         sent_halt   <= 1'b0;
      end else begin
         outstanding <= outstanding + (accept ? 1 : 0) - (trace_valid ? 1 : 0);
         if (rvfi_valid) begin
            seen_strobe <= 1'b1;
         end
         if (accept) begin
            exp_mem[wr_idx] <= new_rec;
            wr_idx          <= wr_idx + 6'd1;
            have_order      <= 1'b1;
            last_order      <= rvfi.order;
            held_cause      <= new_rec.nmi_cause;
         end
         if (trace_valid) begin
            rd_idx  <= rd_idx + 6'd1;
            msg_rec <= exp_head;
            if (!overflow) begin
               exp_pend[NET_NMI_CAUSE]  <= exp_head.nmi_cause != sent_cause;
               exp_pend[NET_NMI]        <= exp_head.nmi != sent_nmi;
               exp_pend[NET_IBUS_FAULT] <= exp_head.ibus_fault != sent_ibus;
               exp_pend[NET_HALTREQ]    <= exp_head.haltreq != sent_halt;
            end
         end
         // Sent levels follow the messages actually seen
         if (net_valid) begin
            exp_pend[net.id] <= 1'b0;
            case (net.id)
               NET_NMI_CAUSE:  sent_cause <= net.value;
               NET_NMI:        sent_nmi   <= net.value[0];
               NET_IBUS_FAULT: sent_ibus  <= net.value[0];
               default:        sent_halt  <= net.value[0];
            endcase
         end
      end
   end

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////
   a_reset_quiet: assert property (@(posedge rvvi) disable iff (!rst_n)
      !seen_strobe |-> !trace_valid && !net_valid && !overflow)
      else begin
         $error("FAIL %0t: output strobe or overflow before the first retirement", $time);
         f_quiet = 1'b1;
      end

   a_trace_known: assert property (@(posedge rvvi) disable iff (!rst_n)
      trace_valid |-> outstanding > 0)
      else begin
         $error("FAIL %0t: trace without an accepted retirement", $time);
         f_known = 1'b1;
      end

   a_trace_match: assert property (@(posedge rvvi) disable iff (!rst_n)
      trace_valid && !overflow |-> trace == exp_head)
      else begin
         $error("FAIL %0t: trace order %0h differs from expected order %0h",
                $time, trace.order, exp_head.order);
         f_match = 1'b1;
      end

   a_msg_window: assert property (@(posedge rvvi) disable iff (!rst_n)
      net_valid && !overflow |-> exp_pend != '0)
      else begin
         $error("FAIL %0t: net message with no pending net change", $time);
         f_window = 1'b1;
      end

   a_msgs_done: assert property (@(posedge rvvi) disable iff (!rst_n)
      trace_valid && !overflow |-> exp_pend == '0)
      else begin
         $error("FAIL %0t: trace before all net messages were sent", $time);
         f_done = 1'b1;
      end

   a_msg_order: assert property (@(posedge rvvi) disable iff (!rst_n)
      net_valid && !overflow |-> net.id == exp_id && net.value == exp_value)
      else begin
         $error("FAIL %0t: net message id %0d value %0h, expected id %0d value %0h",
                $time, net.id, net.value, exp_id, exp_value);
         f_order = 1'b1;
      end

   a_msg_change: assert property (@(posedge rvvi) disable iff (!rst_n)
      net_valid |-> net.value != prev_value)
      else begin
         $error("FAIL %0t: net %0d sent again with unchanged value", $time, net.id);
         f_change = 1'b1;
      end

   // More records in flight than decoder, buffer and sequencer can hold
   a_overflow: assert property (@(posedge rvvi) disable iff (!rst_n)
      outstanding >= 12 |-> ##2 overflow)
      else begin
         $error("FAIL %0t: records lost without overflow flag", $time);
         f_ovf = 1'b1;
      end

endmodule

/* test/tb_clock_gen.sv */
/*
 * Clock and reset source for the trace bridge testbench.
 * 8 ns clock, reset held low for the first 3 rising edges.
 */
module tb_clock_gen (
   output logic rvvi,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      rvvi = 1'b0;
      forever #4 rvvi = ~rvvi;
   end

   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge rvvi);
      #1;
      rst_n = 1'b1;
   end

endmodule

/* test/tb_rvfi_trace_bridge.sv */
/*
 * Testbench top for the RVFI to RVVI trace bridge.
 * Sends random retirements in bursts with repeated orders, then a long
 * burst that overruns the record buffer. The bound checker judges results.
 */
`include "bridge_settings.svh"

module tb_rvfi_trace_bridge
   import trace_pkg::*;
   import net_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_CYCLES = 2000;
   localparam int QUIET_CYCLES = 8;

   logic       rvvi;
   logic       rst_n;
   logic       rvfi_valid;
   rvfi_rec_t  rvfi;
   logic       trace_valid;
   trace_rec_t trace;
   logic       net_valid;
   net_msg_t   net;
   logic       overflow;

   int unsigned                cycles;
   int unsigned                expect_traces;
   int unsigned                seen_traces;
   logic [`BRIDGE_ORDER_W-1:0] next_order;
   logic [`BRIDGE_ORDER_W-1:0] prev_order;
   logic                       have_prev;

   tb_clock_gen i_tb_clock_gen (
      .rvvi  (rvvi),
      .rst_n (rst_n)
   );

   rvfi_trace_bridge i_rvfi_trace_bridge (
      .rvvi        (rvvi),
      .rst_n       (rst_n),
      .rvfi_valid  (rvfi_valid),
      .rvfi        (rvfi),
      .trace_valid (trace_valid),
      .trace       (trace),
      .net_valid   (net_valid),
      .net         (net),
      .overflow    (overflow)
   );

   bind rvfi_trace_bridge bridge_assertions u_assert (.*);

   ////////////////////////////////////////////////////
   // Watchdog and failure stop
   ////////////////////////////////////////////////////
   always @(posedge rvvi) begin
      cycles = cycles + 1;
      if (trace_valid) begin
         seen_traces = seen_traces + 1;
      end
      if (i_rvfi_trace_bridge.u_assert.failed) begin
         $display("Test failed");
         $fatal(1, "Stopped at the first failed check");
      end else if (cycles >= MAX_CYCLES) begin
         $display("Test failed");
         $fatal(1, "Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      end
   end

   // Random retirement with one of a few event kinds
   function automatic rvfi_rec_t random_record(input logic [`BRIDGE_ORDER_W-1:0] order);
      rvfi_rec_t r;
      r           = '0;
      r.order     = order;
      r.insn      = $urandom;
      r.mode      = 2'($urandom_range(0, 3));
      r.ixl       = 2'($urandom_range(1, 2));
      r.pc_rdata  = $urandom;
      r.pc_wdata  = $urandom;
      r.rd_addr   = 5'($urandom_range(0, 31));
      r.rd_wdata  = $urandom;
      r.csr_addr  = 12'($urandom_range(0, 4095));
      r.csr_wdata = $urandom;
      r.csr_wmask = ($urandom_range(0, 3) == 0) ? 32'h0 : $urandom;
      r.csr_rdata = $urandom;
      r.intr.cause = 11'($urandom_range(0, 1023));
      case ($urandom_range(0, 7))
         0: begin
            r.trap.trap            = 1'b1;
            r.trap.exception       = 1'b1;
            r.trap.exception_cause = 6'(`BRIDGE_CAUSE_IBUS_FAULT);
         end
         1: begin
            r.trap.trap            = 1'b1;
            r.trap.exception       = 1'b1;
            r.trap.exception_cause = 6'($urandom_range(0, 47));
         end
         2: begin
            r.intr.intr      = 1'b1;
            r.intr.interrupt = 1'b1;
            r.intr.cause     = 11'($urandom_range(`BRIDGE_NMI_LOAD_CAUSE,
                                                  `BRIDGE_NMI_STORE_CAUSE));
         end
         3: r.nmip = 2'b01;
         4: begin
            r.dbg      = 3'(`BRIDGE_DBG_HALTREQ);
            r.dbg_mode = 1'b1;
         end
         default: r.dbg = 3'($urandom_range(0, 2));
      endcase
      return r;
   endfunction

   task automatic drive(input logic valid, input rvfi_rec_t rec);
      @(posedge rvvi);
      #1;
      rvfi_valid = valid;
      rvfi       = rec;
   endtask

   // New order, or the last accepted one again when repeat is set
   task automatic send_record(input logic repeat_order);
      rvfi_rec_t rec;
      if (repeat_order && have_prev) begin
         rec = random_record(prev_order);
      end else begin
         rec           = random_record(next_order);
         prev_order    = next_order;
         have_prev     = 1'b1;
         next_order    = next_order + 1;
         expect_traces = expect_traces + 1;
      end
      drive(1'b1, rec);
   endtask

   task automatic wait_drained();
      drive(1'b0, rvfi);
      while (seen_traces != expect_traces) begin
         drive(1'b0, rvfi);
      end
   endtask

   // Sequencer leaves at most one idle cycle between records it holds
   task automatic wait_quiet();
      int unsigned quiet;
      quiet = 0;
      while (quiet < QUIET_CYCLES) begin
         drive(1'b0, rvfi);
         if (trace_valid || net_valid) begin
            quiet = 0;
         end else begin
            quiet = quiet + 1;
         end
      end
   endtask

   initial begin
      rvfi_rec_t rec;
      rvfi_valid    = 1'b0;
      rvfi          = '0;
      cycles        = 0;
      expect_traces = 0;
      seen_traces   = 0;
      next_order    = 64'h100;
      prev_order    = '0;
      have_prev     = 1'b0;
      void'($urandom(32'h8955_4953));

      @(posedge rst_n);
      repeat (4) drive(1'b0, rvfi);

      // Sparse records first
      for (int i = 0; i < 6; i++) begin
         send_record($urandom_range(0, 3) == 0);
         repeat (8) drive(1'b0, rvfi);
      end
      wait_drained();

      // Back-to-back bursts with repeated orders
      for (int b = 0; b < 6; b++) begin
         for (int i = 0; i < 12; i++) begin
            send_record($urandom_range(0, 2) == 0);
         end
         wait_drained();
      end

      // Long burst where the 1-bit nets flip on every record
      for (int i = 0; i < 20; i++) begin
         rec = random_record(next_order);
         rec.trap  = '0;
         rec.intr  = '0;
         rec.nmip  = 2'b00;
         rec.dbg   = 3'd0;
         rec.dbg_mode = 1'b0;
         if (i % 2 == 0) begin
            rec.intr.cause             = 11'($urandom_range(1, 1023));
            rec.nmip                   = 2'b01;
            rec.trap.trap              = 1'b1;
            rec.trap.exception         = 1'b1;
            rec.trap.exception_cause   = 6'(`BRIDGE_CAUSE_IBUS_FAULT);
            rec.dbg                    = 3'(`BRIDGE_DBG_HALTREQ);
            rec.dbg_mode               = 1'b1;
         end
         next_order = next_order + 1;
         drive(1'b1, rec);
      end
      drive(1'b0, rvfi);
      while (!overflow) begin
         @(posedge rvvi);
      end
      wait_quiet();

      if (i_rvfi_trace_bridge.u_assert.failed) begin
         $display("Test failed");
         $fatal(1, "A check failed before the end of the run");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule
